//--- include/font_glyphs.svh
`ifndef FONT_GLYPHS_SVH
`define FONT_GLYPHS_SVH

// hex digits 0-f, eight rows each, msb is the leftmost pixel
localparam logic [7:0] font_glyphs [16][8] = '{
	'{8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c, 8'h00},  // 0
	'{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00},  // 1
	'{8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e, 8'h00},  // 2
	'{8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00},  // 3
	'{8'h0c, 8'h1c, 8'h3c, 8'h6c, 8'h7e, 8'h0c, 8'h0c, 8'h00},  // 4
	'{8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00},  // 5
	'{8'h3c, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h66, 8'h3c, 8'h00},  // 6
	'{8'h7e, 8'h06, 8'h0c, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},  // 7
	'{8'h3c, 8'h66, 8'h66, 8'h3c, 8'h66, 8'h66, 8'h3c, 8'h00},  // 8
	'{8'h3c, 8'h66, 8'h66, 8'h3e, 8'h06, 8'h0c, 8'h38, 8'h00},  // 9
	'{8'h18, 8'h3c, 8'h66, 8'h66, 8'h7e, 8'h66, 8'h66, 8'h00},  // a
	'{8'h7c, 8'h66, 8'h66, 8'h7c, 8'h66, 8'h66, 8'h7c, 8'h00},  // b
	'{8'h3c, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3c, 8'h00},  // c
	'{8'h78, 8'h6c, 8'h66, 8'h66, 8'h66, 8'h6c, 8'h78, 8'h00},  // d
	'{8'h7e, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h7e, 8'h00},  // e
	'{8'h7e, 8'h60, 8'h60, 8'h78, 8'h60, 8'h60, 8'h60, 8'h00}   // f
};

`endif

//--- logic/vdu_pkg.sv
package vdu_pkg;

	// 480x272 panel raster, active area first
	localparam int H_RES   = 480;
	localparam int V_RES   = 272;
	localparam int H_FP    = 2;
	localparam int H_SYNC  = 41;
	localparam int H_BP    = 2;
	localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 525
	localparam int V_FP    = 2;
	localparam int V_SYNC  = 10;
	localparam int V_BP    = 2;
	localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 286

	localparam int H_SYNC_START = H_RES + H_FP;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
	localparam int V_SYNC_START = V_RES + V_FP;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	localparam int CORDW = 10;  // unsigned coordinate width

	// text window of 16x8 cells of 8x8 pixels
	localparam int TEXT_COLS  = 16;
	localparam int TEXT_ROWS  = 8;
	localparam int GLYPH_SIZE = 8;
	localparam int X_OFFSET   = 176;  // (480 - 128) / 2
	localparam int Y_OFFSET   = 8;
	localparam int TEXT_W     = TEXT_COLS * GLYPH_SIZE;
	localparam int TEXT_H     = TEXT_ROWS * GLYPH_SIZE;
	localparam int GLYPH_W    = $clog2(GLYPH_SIZE);  // pixel index bits inside a cell
	localparam int COL_W      = $clog2(TEXT_COLS);
	localparam int ROW_W      = $clog2(TEXT_ROWS);

	localparam int ADDR_W   = 16;
	localparam int TEXT_LAT = 3;  // coordinate to drawing bit

	// apb register byte offsets
	localparam logic [3:0] REG_CTRL = 4'd0;
	localparam logic [3:0] REG_BASE = 4'd4;
	localparam logic [3:0] REG_FG   = 4'd8;
	localparam logic [3:0] REG_BG   = 4'd12;

	// rgb565 reset colours
	localparam logic [15:0] FG_RESET = 16'hffe0;  // yellow
	localparam logic [15:0] BG_RESET = 16'h0010;  // dark blue

endpackage

//--- logic/display_timing.sv
module display_timing (
	input  wire logic                      clk_pix,
	input  wire logic                      i_rst_n,
	output      logic [vdu_pkg::CORDW-1:0] o_sx,
	output      logic [vdu_pkg::CORDW-1:0] o_sy,
	output      logic                      o_hsync,
	output      logic                      o_vsync,
	output      logic                      o_de,
	output      logic                      o_frame,
	output      logic                      o_line,
	output      logic                      o_hsync_d,
	output      logic                      o_vsync_d,
	output      logic                      o_de_d
);
	import vdu_pkg::*;

	logic [TEXT_LAT-1:0] hsync_pipe;  // index 0 is the newest
	logic [TEXT_LAT-1:0] vsync_pipe;
	logic [TEXT_LAT-1:0] de_pipe;
	logic                end_of_line;

	assign end_of_line = (o_sx == CORDW'(H_TOTAL - 1));

	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			o_sx <= '0;
			o_sy <= '0;
		end else if (end_of_line) begin
			o_sx <= '0;
			if (o_sy == CORDW'(V_TOTAL - 1))
				o_sy <= '0;  // wrap to the next frame
			else
				o_sy <= o_sy + 1'b1;
		end else begin
			o_sx <= o_sx + 1'b1;
		end
	end

	// sync is active low inside its window
	always_comb begin
		o_hsync = !((o_sx >= CORDW'(H_SYNC_START)) && (o_sx < CORDW'(H_SYNC_END)));
		o_vsync = !((o_sy >= CORDW'(V_SYNC_START)) && (o_sy < CORDW'(V_SYNC_END)));
		o_de    = (o_sx < CORDW'(H_RES)) && (o_sy < CORDW'(V_RES));
		o_line  = (o_sx == '0);
		o_frame = (o_sx == '0) && (o_sy == '0);
	end

	// line up sync and enable with the drawing bit of the text engine
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			hsync_pipe <= '1;
			vsync_pipe <= '1;
			de_pipe    <= '0;
		end else begin
			hsync_pipe <= {hsync_pipe[TEXT_LAT-2:0], o_hsync};
			vsync_pipe <= {vsync_pipe[TEXT_LAT-2:0], o_vsync};
			de_pipe    <= {de_pipe[TEXT_LAT-2:0], o_de};
		end
	end

	assign o_hsync_d = hsync_pipe[TEXT_LAT-1];
	assign o_vsync_d = vsync_pipe[TEXT_LAT-1];
	assign o_de_d    = de_pipe[TEXT_LAT-1];

endmodule

//--- logic/vdu_regs.sv
module vdu_regs (
	input  wire logic                       clk_pix,
	input  wire logic                       i_rst_n,
	input  wire logic                       i_psel,
	input  wire logic                       i_penable,
	input  wire logic                       i_pwrite,
	input  wire logic [3:0]                 i_paddr,
	input  wire logic [31:0]                i_pwdata,
	output      logic [31:0]                o_prdata,
	output      logic                       o_pready,
	output      logic                       o_pslverr,
	input  wire logic                       i_frame,
	output      logic                       o_enable,
	output      logic [vdu_pkg::ADDR_W-1:0] o_base,
	output      logic [15:0]                o_fg,
	output      logic [15:0]                o_bg
);
	import vdu_pkg::*;

	logic              ctrl_en;   // register copies seen by apb
	logic [ADDR_W-1:0] base_reg;
	logic [15:0]       fg_reg;
	logic [15:0]       bg_reg;
	logic              access;    // apb access phase
	logic              mapped;

	assign access    = i_psel && i_penable;
	assign o_pready  = 1'b1;  // no wait states
	assign o_pslverr = access && !mapped;

	// read mux, also flags the four valid offsets
	always_comb begin
		mapped = 1'b1;
		case (i_paddr)
			REG_CTRL: o_prdata = {31'd0, ctrl_en};
			REG_BASE: o_prdata = {{(32 - ADDR_W){1'b0}}, base_reg};
			REG_FG:   o_prdata = {16'd0, fg_reg};
			REG_BG:   o_prdata = {16'd0, bg_reg};
			default: begin
				o_prdata = '0;
				mapped   = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			ctrl_en  <= 1'b0;
			base_reg <= '0;
			fg_reg   <= FG_RESET;
			bg_reg   <= BG_RESET;
		end else if (access && i_pwrite) begin
			case (i_paddr)
				REG_CTRL: ctrl_en  <= i_pwdata[0];
				REG_BASE: base_reg <= i_pwdata[ADDR_W-1:0];
				REG_FG:   fg_reg   <= i_pwdata[15:0];
				REG_BG:   bg_reg   <= i_pwdata[15:0];
				default: ;  // unmapped write is dropped
			endcase
		end
	end

	// datapath copies only move at the frame boundary
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			o_enable <= 1'b0;
			o_base   <= '0;
			o_fg     <= FG_RESET;
			o_bg     <= BG_RESET;
		end else if (i_frame) begin
			o_enable <= ctrl_en;
			o_base   <= base_reg;
			o_fg     <= fg_reg;
			o_bg     <= bg_reg;
		end
	end

endmodule

//--- logic/vdu_text.sv
`include "font_glyphs.svh"

module vdu_text (
	input  wire logic                       clk_pix,
	input  wire logic                       i_rst_n,
	input  wire logic                       i_enable,
	input  wire logic [vdu_pkg::ADDR_W-1:0] i_base,
	input  wire logic [vdu_pkg::CORDW-1:0]  i_sx,
	input  wire logic [vdu_pkg::CORDW-1:0]  i_sy,
	output      logic                       o_read_en,
	output      logic [vdu_pkg::ADDR_W-1:0] o_read_addr,
	input  wire logic [7:0]                 i_display_data,
	output      logic                       o_drawing
);
	import vdu_pkg::*;

	logic [CORDW-1:0]   win_x;       // pixel offset from window origin
	logic [CORDW-1:0]   win_y;
	logic               in_win;
	logic               fetch;       // first pixel of a cell
	logic [COL_W-1:0]   cell_col;
	logic [ROW_W-1:0]   cell_row;

	logic               in_win_p1;   // stage 1 outputs
	logic [GLYPH_W-1:0] row_p1;
	logic               load_p2;     // stage 2 outputs
	logic               in_win_p2;
	logic [GLYPH_W-1:0] row_p2;

	logic [7:0]         glyph_bits;
	logic [7:0]         shifter;     // msb is the current pixel

	// stage 0, window decode from the raster position
	always_comb begin
		win_x    = i_sx - CORDW'(X_OFFSET);
		win_y    = i_sy - CORDW'(Y_OFFSET);
		in_win   = (i_sx >= CORDW'(X_OFFSET)) && (i_sx < CORDW'(X_OFFSET + TEXT_W))
			&& (i_sy >= CORDW'(Y_OFFSET)) && (i_sy < CORDW'(Y_OFFSET + TEXT_H));
		cell_col = win_x[GLYPH_W +: COL_W];
		cell_row = win_y[GLYPH_W +: ROW_W];
		fetch    = i_enable && in_win && (win_x[GLYPH_W-1:0] == '0);
	end

	// stage 1, issue the memory read at base + row*16 + col
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			o_read_en <= 1'b0;
			in_win_p1 <= 1'b0;
		end else begin
			o_read_en <= fetch;
			in_win_p1 <= in_win;
		end
	end

	always_ff @(posedge clk_pix) begin
		if (fetch)
			o_read_addr <= i_base + ADDR_W'({cell_row, cell_col});
		row_p1 <= win_y[GLYPH_W-1:0];  // glyph row rides along
	end

	// stage 2, memory byte arrives this cycle
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			load_p2   <= 1'b0;
			in_win_p2 <= 1'b0;
		end else begin
			load_p2   <= o_read_en;
			in_win_p2 <= in_win_p1;
		end
	end

	always_ff @(posedge clk_pix) begin
		row_p2 <= row_p1;
	end

	// upper nibble of the character byte is ignored
	assign glyph_bits = font_glyphs[i_display_data[3:0]][row_p2];

	// stage 3, serialize the glyph row left to right
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n)
			shifter <= '0;
		else if (load_p2)
			shifter <= glyph_bits;
		else if (in_win_p2)
			shifter <= {shifter[6:0], 1'b0};
		else
			shifter <= '0;  // blank outside the window
	end

	assign o_drawing = shifter[7];

endmodule

//--- logic/vdu_lcd272.sv
module vdu_lcd272 (
	input  wire logic                       clk_pix,
	input  wire logic                       i_rst_n,
	input  wire logic                       i_psel,
	input  wire logic                       i_penable,
	input  wire logic                       i_pwrite,
	input  wire logic [3:0]                 i_paddr,
	input  wire logic [31:0]                i_pwdata,
	output      logic [31:0]                o_prdata,
	output      logic                       o_pready,
	output      logic                       o_pslverr,
	output      logic                       o_read_en,
	output      logic [vdu_pkg::ADDR_W-1:0] o_read_addr,
	input  wire logic [7:0]                 i_display_data,
	output      logic                       o_lcd_clk,
	output      logic                       o_lcd_hsync,
	output      logic                       o_lcd_vsync,
	output      logic                       o_lcd_de,
	output      logic [4:0]                 o_lcd_r,
	output      logic [5:0]                 o_lcd_g,
	output      logic [4:0]                 o_lcd_b
);
	import vdu_pkg::*;

	logic [CORDW-1:0]  sx;
	logic [CORDW-1:0]  sy;
	logic              frame;
	logic              hsync_d;     // aligned with drawing
	logic              vsync_d;
	logic              de_d;
	logic              enable;      // frame-stable register copies
	logic [ADDR_W-1:0] base;
	logic [15:0]       fg;
	logic [15:0]       bg;
	logic              drawing;
	logic [15:0]       paint;       // rgb565

	display_timing u_timing (
		.clk_pix   (clk_pix),
		.i_rst_n   (i_rst_n),
		.o_sx      (sx),
		.o_sy      (sy),
		.o_hsync   (),
		.o_vsync   (),
		.o_de      (),
		.o_frame   (frame),
		.o_line    (),
		.o_hsync_d (hsync_d),
		.o_vsync_d (vsync_d),
		.o_de_d    (de_d)
	);

	vdu_regs u_regs (
		.clk_pix   (clk_pix),
		.i_rst_n   (i_rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.i_frame   (frame),
		.o_enable  (enable),
		.o_base    (base),
		.o_fg      (fg),
		.o_bg      (bg)
	);

	vdu_text u_text (
		.clk_pix        (clk_pix),
		.i_rst_n        (i_rst_n),
		.i_enable       (enable),
		.i_base         (base),
		.i_sx           (sx),
		.i_sy           (sy),
		.o_read_en      (o_read_en),
		.o_read_addr    (o_read_addr),
		.i_display_data (i_display_data),
		.o_drawing      (drawing)
	);

	assign paint     = drawing ? fg : bg;
	assign o_lcd_clk = clk_pix;

	// one register stage to the pins
	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			o_lcd_hsync <= 1'b1;
			o_lcd_vsync <= 1'b1;
			o_lcd_de    <= 1'b0;
			o_lcd_r     <= '0;
			o_lcd_g     <= '0;
			o_lcd_b     <= '0;
		end else begin
			o_lcd_hsync <= hsync_d;
			o_lcd_vsync <= vsync_d;
			o_lcd_de    <= de_d;
			{o_lcd_r, o_lcd_g, o_lcd_b} <= de_d ? paint : 16'h0000;  // black in blanking
		end
	end

endmodule

//--- test/vdu_checker.sv
`include "font_glyphs.svh"

module vdu_checker (
	input wire logic                       clk_pix,
	input wire logic                       i_rst_n,
	input wire logic                       i_psel,
	input wire logic                       i_penable,
	input wire logic                       i_pwrite,
	input wire logic [3:0]                 i_paddr,
	input wire logic [31:0]                i_pwdata,
	input wire logic                       o_read_en,
	input wire logic [vdu_pkg::ADDR_W-1:0] o_read_addr,
	input wire logic [7:0]                 i_display_data,
	input wire logic                       o_lcd_clk,
	input wire logic                       o_lcd_hsync,
	input wire logic                       o_lcd_vsync,
	input wire logic                       o_lcd_de,
	input wire logic [4:0]                 o_lcd_r,
	input wire logic [5:0]                 o_lcd_g,
	input wire logic [4:0]                 o_lcd_b
);
	timeunit 1ns;
	timeprecision 1ps;
	import vdu_pkg::*;

	int                errors;
	logic              hs_q, vs_q, de_q, h_seen, v_seen, rd_q;
	int                h_gap, v_gap, px, py, wx, wy;  // px/py follow the pins
	logic              m_en, sh_en;                   // register model and its frame copy
	logic [ADDR_W-1:0] m_base, sh_base, addr_q, cell_addr, rd_off;
	logic [15:0]       m_fg, m_bg, sh_fg, sh_bg, exp_col, pins;
	logic [7:0]        byte_at [65536];               // bytes the memory returned
	logic [7:0]        glyph;
	logic [2:0]        gx, gy;
	logic              in_win, hs_fall, vs_fall, de_fall;
	logic              frame_start;                   // raster at (0,0), ahead of the pins

	assign hs_fall = hs_q && !o_lcd_hsync;
	assign vs_fall = vs_q && !o_lcd_vsync;
	assign de_fall = de_q && !o_lcd_de;
	assign pins    = {o_lcd_r, o_lcd_g, o_lcd_b};
	assign rd_off  = o_read_addr - sh_base;

	// sync lines plus back porch after the vsync edge, minus the pin latency
	assign frame_start = v_seen && (v_gap == (V_SYNC + V_BP) * H_TOTAL - (TEXT_LAT + 1));

	always_comb begin
		wx        = px - X_OFFSET;
		wy        = py - Y_OFFSET;
		in_win    = (px >= X_OFFSET) && (px < X_OFFSET + TEXT_COLS * GLYPH_SIZE)
			&& (py >= Y_OFFSET) && (py < Y_OFFSET + TEXT_ROWS * GLYPH_SIZE);
		cell_addr = sh_base + ADDR_W'((wy / GLYPH_SIZE) * TEXT_COLS + wx / GLYPH_SIZE);
		gx        = 3'(wx % GLYPH_SIZE);
		gy        = 3'(wy % GLYPH_SIZE);
		glyph     = byte_at[cell_addr];
		exp_col   = (in_win && sh_en && font_glyphs[glyph[3:0]][gy][~gx]) ? sh_fg : sh_bg;
	end

	always_ff @(posedge clk_pix) begin
		if (!i_rst_n) begin
			hs_q    <= 1'b1;
			vs_q    <= 1'b1;
			de_q    <= 1'b0;
			h_seen  <= 1'b0;
			v_seen  <= 1'b0;
			h_gap   <= 0;
			v_gap   <= 0;
			px      <= 0;
			py      <= 0;
			m_en    <= 1'b0;
			sh_en   <= 1'b0;
			m_base  <= '0;
			sh_base <= '0;
			m_fg    <= FG_RESET;
			sh_fg   <= FG_RESET;
			m_bg    <= BG_RESET;
			sh_bg   <= BG_RESET;
		end else begin
			{hs_q, vs_q, de_q} <= {o_lcd_hsync, o_lcd_vsync, o_lcd_de};
			h_gap  <= hs_fall ? 1 : h_gap + 1;
			v_gap  <= vs_fall ? 1 : v_gap + 1;
			h_seen <= h_seen || hs_fall;
			v_seen <= v_seen || vs_fall;
			px     <= o_lcd_de ? px + 1 : 0;
			if (!o_lcd_vsync)
				py <= 0;
			else if (de_fall)
				py <= py + 1;  // next active line
			if (i_psel && i_penable && i_pwrite)
				case (i_paddr)
					REG_CTRL: m_en   <= i_pwdata[0];
					REG_BASE: m_base <= i_pwdata[ADDR_W-1:0];
					REG_FG:   m_fg   <= i_pwdata[15:0];
					REG_BG:   m_bg   <= i_pwdata[15:0];
					default: ;
				endcase
			if (frame_start)
				{sh_en, sh_base, sh_fg, sh_bg} <= {m_en, m_base, m_fg, m_bg};
		end
	end

	// memory answers one cycle after the read
	always_ff @(posedge clk_pix) begin
		rd_q   <= o_read_en;
		addr_q <= o_read_addr;
		if (rd_q)
			byte_at[addr_q] <= i_display_data;
	end

	// panel clock is the pixel clock passed through
	always @(clk_pix) begin
		#1;
		a_lcd_clk: assert (o_lcd_clk === clk_pix)
			else begin
				errors++;
				$error("error at %0t: o_lcd_clk expected %b got %b", $time, clk_pix, o_lcd_clk);
			end
	end

	a_hsync_period: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		(hs_fall && h_seen) |-> (h_gap == H_TOTAL))
		else begin
			errors++;
			$error("error at %0t: o_lcd_hsync period expected %0d got %0d",
				$time, H_TOTAL, $sampled(h_gap));
		end
	a_vsync_period: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		(vs_fall && v_seen) |-> (v_gap == H_TOTAL * V_TOTAL))
		else begin
			errors++;
			$error("error at %0t: o_lcd_vsync period expected %0d got %0d",
				$time, H_TOTAL * V_TOTAL, $sampled(v_gap));
		end
	a_line_width: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		de_fall |-> (px == H_RES))
		else begin
			errors++;
			$error("error at %0t: o_lcd_de cycles per line expected %0d got %0d",
				$time, H_RES, $sampled(px));
		end
	a_blank_black: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		!o_lcd_de |-> (pins == 16'h0000))
		else begin
			errors++;
			$error("error at %0t: o_lcd_r/g/b in blanking expected 0000 got %h",
				$time, $sampled(pins));
		end
	a_fetch_range: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		o_read_en |-> (sh_en && (rd_off < 16'd128)))
		else begin
			errors++;
			$error("read of address %h at %0t while disabled or outside the text window",
				$sampled(o_read_addr), $time);
		end
	a_pixel_colour: assert property (@(posedge clk_pix) disable iff (!i_rst_n)
		o_lcd_de |-> (pins == exp_col))
		else begin
			errors++;
			$error("error at %0t: o_lcd_r/g/b at pixel %0d,%0d expected %h got %h",
				$time, $sampled(px), $sampled(py), $sampled(exp_col), $sampled(pins));
		end

endmodule

//--- test/tb_vdu_lcd272.sv
module tb_vdu_lcd272;
	timeunit 1ns;
	timeprecision 1ps;
	import vdu_pkg::*;

	localparam int APB_LIMIT   = 16;
	localparam int FRAME_LIMIT = H_TOTAL * V_TOTAL + 1000;

	logic        clk_pix, i_rst_n, psel, penable, pwrite, pready, pslverr;
	logic [3:0]  paddr;
	logic [31:0] pwdata, prdata;
	logic        read_en, lcd_clk, lcd_hsync, lcd_vsync, lcd_de;
	logic [15:0] read_addr, rd_addr;
	logic [7:0]  display_data;
	logic [4:0]  lcd_r, lcd_b;
	logic [5:0]  lcd_g;
	logic [7:0]  mem [65536];
	integer      seed;
	int          errors;

	vdu_lcd272 u_dut (
		.clk_pix(clk_pix), .i_rst_n(i_rst_n), .i_psel(psel), .i_penable(penable),
		.i_pwrite(pwrite), .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata),
		.o_pready(pready), .o_pslverr(pslverr), .o_read_en(read_en),
		.o_read_addr(read_addr), .i_display_data(display_data), .o_lcd_clk(lcd_clk),
		.o_lcd_hsync(lcd_hsync), .o_lcd_vsync(lcd_vsync), .o_lcd_de(lcd_de),
		.o_lcd_r(lcd_r), .o_lcd_g(lcd_g), .o_lcd_b(lcd_b)
	);

	bind vdu_lcd272 vdu_checker u_checker (
		.clk_pix(clk_pix), .i_rst_n(i_rst_n), .i_psel(i_psel), .i_penable(i_penable),
		.i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata), .o_lcd_clk(o_lcd_clk),
		.o_read_en(o_read_en), .o_read_addr(o_read_addr), .i_display_data(i_display_data),
		.o_lcd_hsync(o_lcd_hsync), .o_lcd_vsync(o_lcd_vsync), .o_lcd_de(o_lcd_de),
		.o_lcd_r(o_lcd_r), .o_lcd_g(o_lcd_g), .o_lcd_b(o_lcd_b)
	);

	initial begin
		clk_pix = 1'b0;
		forever #5 clk_pix = ~clk_pix;
	end

	// display memory, data one cycle after the read
	always @(posedge clk_pix) begin
		if (read_en) begin
			rd_addr = read_addr;
			#1 display_data = mem[rd_addr];
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("tests failed");
		$finish;
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
			input logic [31:0] exp_rd, input logic exp_err);
		int n;
		@(posedge clk_pix);
		#1 {psel, penable, pwrite, paddr, pwdata} = {1'b1, 1'b0, wr, addr, data};
		@(posedge clk_pix);
		#1 penable = 1'b1;
		n = 0;
		@(posedge clk_pix);
		while (!pready && n < APB_LIMIT) begin
			@(posedge clk_pix);
			n++;
		end
		if (!pready)
			stop_on_timeout("APB slave never raised pready");
		if (!wr && prdata !== exp_rd) begin
			errors++;
			$display("error at %0t: o_prdata expected %h got %h", $time, exp_rd, prdata);
		end
		if (pslverr !== exp_err) begin
			errors++;
			$display("error at %0t: o_pslverr expected %b got %b", $time, exp_err, pslverr);
		end
		#1 {psel, penable, pwrite} = 3'b000;
	endtask

	task automatic wait_frames(input int count);
		int   n;
		logic prev, seen;
		repeat (count) begin
			n    = 0;
			seen = 1'b0;
			while (!seen && n < FRAME_LIMIT) begin
				prev = lcd_vsync;
				@(posedge clk_pix);
				n++;
				seen = prev && !lcd_vsync;  // vsync falling edge
			end
			if (!seen)
				stop_on_timeout("vsync did not fall within a frame time");
		end
	endtask

	initial begin
		seed = 32'haa64;
		errors = 0;
		for (int i = 0; i < 65536; i++)
			mem[16'(i)] = 8'($random(seed));
		{i_rst_n, psel, penable, pwrite, paddr, pwdata, display_data} = '0;
		repeat (16) @(posedge clk_pix);
		#1 i_rst_n = 1'b1;
		wait_frames(1);
		apb_access(1'b1, REG_BASE, 32'h0000_1340, '0, 1'b0);
		apb_access(1'b1, REG_FG, 32'h0000_f81f, '0, 1'b0);
		apb_access(1'b1, REG_BG, 32'h0000_2104, '0, 1'b0);
		apb_access(1'b0, REG_CTRL, '0, 32'h0, 1'b0);
		apb_access(1'b0, REG_BASE, '0, 32'h0000_1340, 1'b0);
		apb_access(1'b0, REG_FG, '0, 32'h0000_f81f, 1'b0);
		apb_access(1'b0, REG_BG, '0, 32'h0000_2104, 1'b0);
		apb_access(1'b1, 4'd6, 32'hdead_beef, '0, 1'b1);
		apb_access(1'b0, 4'd6, '0, 32'h0, 1'b1);
		apb_access(1'b1, REG_CTRL, 32'h1, '0, 1'b0);
		apb_access(1'b0, REG_CTRL, '0, 32'h1, 1'b0);
		wait_frames(2);
		// land inside the text rows of the next frame
		repeat ((V_TOTAL - V_RES - V_FP + 40) * H_TOTAL) @(posedge clk_pix);
		apb_access(1'b1, REG_BASE, 32'h0000_ffc0, '0, 1'b0);
		apb_access(1'b1, REG_FG, 32'h0000_07e0, '0, 1'b0);
		apb_access(1'b1, REG_BG, 32'h0000_0000, '0, 1'b0);
		wait_frames(2);
		apb_access(1'b1, REG_CTRL, 32'h0, '0, 1'b0);
		wait_frames(2);
		$display("errors: testbench %0d, checker %0d", errors, u_dut.u_checker.errors);
		if (errors == 0 && u_dut.u_checker.errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
logic/vdu_pkg.sv
logic/display_timing.sv
logic/vdu_regs.sv
logic/vdu_text.sv
logic/vdu_lcd272.sv
test/vdu_checker.sv
test/tb_vdu_lcd272.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_vdu_lcd272
FILELIST  = vlog.f
BUILD     = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000
FAIL_MSG  = tests failed
PASS_MSG  = all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
